//--- qdr_pkg.sv
package qdr_pkg;

  // cycles from a read grant to the first read beat on dev_q
  localparam int qdr_latency = 10;

  // host bus word
  localparam int host_data_w = 32;

  // one QDR beat is two 36-bit lanes
  localparam int beat_w = 72;

  // one burst is two beats
  localparam int burst_w = 144;

  // host word plus four zero pad bits where parity would sit
  localparam int lane_w = 36;

  // host byte address bits 31 to 4
  localparam int burst_addr_w = 28;

  // single host transfer, held stable by the host until host_ack
  typedef struct packed {
    // 1 for a read, 0 for a write
    logic                   rnw;
    // byte address, bits 3 to 2 pick the word in the burst
    logic [31:0]            addr;
    logic [host_data_w-1:0] wdata;
    // one enable per host byte
    logic [3:0]             be;
  } host_req_t;

  // burst command from the bridge to the sequencer
  typedef struct packed {
    // read strobe, only while the request is pending
    logic                    r;
    // write strobe, only while the request is pending
    logic                    w;
    // burst address
    logic [burst_addr_w-1:0] addr;
    // current beat, beat 0 in the ack cycle and beat 1 after it
    logic [beat_w-1:0]       d;
    // one enable per 9-bit byte of the current beat
    logic [7:0]              be;
  } qdr_cmd_t;

endpackage

//--- host_xfer_sync.sv
`timescale 1ns/100ps

module host_xfer_sync (
  input  logic host_clk,
  input  logic host_rst,
  input  logic host_en,
  input  logic resp,
  output logic trans,
  output logic host_ack
);

  // four-phase handshake, host side
  //   idle       waiting for host_en
  //   wait_resp  trans high until the memory side answers
  //   wait_clear trans low, wait for resp to drop before acking
  typedef enum logic [1:0] {
    x_idle,
    x_wait_resp,
    x_wait_clear
  } xfer_state_t;

  xfer_state_t state;

  // two-flop synchronizer for resp coming from qdr_clk
  logic resp_r;
  logic resp_rr;

  always_ff @(posedge host_clk) begin
    if (host_rst) begin
      resp_r  <= 1'b0;
      resp_rr <= 1'b0;
    end else begin
      resp_r  <= resp;
      resp_rr <= resp_r;
    end
  end

  // trans is a flop of its own so the crossing sees a clean level
  always_ff @(posedge host_clk) begin
    if (host_rst) begin
      state    <= x_idle;
      trans    <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      // ack is a single-cycle pulse
      host_ack <= 1'b0;
      case (state)
        x_idle: begin
          if (host_en) begin
            trans <= 1'b1;
            state <= x_wait_resp;
          end
        end
        x_wait_resp: begin
          // memory side done, rdata is already stable
          if (resp_rr) begin
            trans <= 1'b0;
            state <= x_wait_clear;
          end
        end
        x_wait_clear: begin
          // resp low again means the bridge is back in idle
          if (!resp_rr) begin
            host_ack <= 1'b1;
            state    <= x_idle;
          end
        end
        default: begin
          trans <= 1'b0;
          state <= x_idle;
        end
      endcase
    end
  end

endmodule

//--- qdr_cpu_bridge.sv
`timescale 1ns/100ps

module qdr_cpu_bridge (
  input  logic                            qdr_clk,
  input  logic                            qdr_rst,
  input  logic                            trans,
  input  qdr_pkg::host_req_t              host_req,
  input  logic                            cmd_ack,
  input  logic [qdr_pkg::beat_w-1:0]      dev_q,
  output logic                            resp,
  output logic [qdr_pkg::host_data_w-1:0] rdata,
  output logic                            cmd_req,
  output qdr_pkg::qdr_cmd_t               cmd,
  output logic                            sniff_strobe
);

  import qdr_pkg::*;

  // handshake with the host side
  typedef enum logic [1:0] {
    hs_idle,
    hs_prepare,
    hs_busy
  } hs_state_t;

  // burst request and response collection
  typedef enum logic [1:0] {
    rs_idle,
    rs_wait,
    rs_collect,
    rs_final
  } rs_state_t;

  hs_state_t hs_state;
  rs_state_t rs_state;

  // trans synchronizer
  logic trans_r;
  logic trans_rr;

  // captured host request, host_req is only stable while trans is high
  host_req_t req_q;

  // shadow of the whole burst, rewritten to memory on every write
  logic [burst_w-1:0] shadow;

  // high in the cycle after the ack, beat 1 goes out then
  logic second_beat;

  // one bit per cycle of read latency, marks when beat 0 returns
  logic [qdr_latency-1:0] ret_line;

  logic [1:0]        word_id;
  logic [lane_w-1:0] wr_lane;
  logic [7:0]        lane_be;
  logic              burst_start;
  logic              burst_done;
  logic              take_q;

  // address bit 3 picks the beat, bit 2 the lane
  assign word_id = req_q.addr[3:2];

  // zero the pad bits above each host word
  assign wr_lane = {{(lane_w - host_data_w){1'b0}}, req_q.wdata};

  // host byte enables moved onto the addressed lane
  assign lane_be = word_id[0] ? {req_q.be, 4'b0000} : {4'b0000, req_q.be};

  // prepare cycle updates the shadow and starts the burst
  assign burst_start = (hs_state == hs_prepare);

  // sample dev_q for a read
  // beat 0 when the latency line runs out, beat 1 one cycle later
  assign take_q = (rs_state == rs_collect && req_q.rnw && ret_line[qdr_latency-1] &&
                   !word_id[1]) || (rs_state == rs_final);

  // writes finish in the cycle after the ack
  assign burst_done = (rs_state == rs_collect && !req_q.rnw) || take_q;

  // held until the sequencer grants
  assign cmd_req = (rs_state == rs_wait);

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      trans_r  <= 1'b0;
      trans_rr <= 1'b0;
      hs_state <= hs_idle;
      resp     <= 1'b0;
    end else begin
      trans_r  <= trans;
      trans_rr <= trans_r;
      case (hs_state)
        hs_idle: begin
          if (trans_rr) begin
            hs_state <= hs_prepare;
          end
        end
        hs_prepare: begin
          hs_state <= hs_busy;
        end
        hs_busy: begin
          if (burst_done) begin
            resp <= 1'b1;
          end
          // host saw resp and dropped trans, release and go again
          if (!trans_rr) begin
            resp     <= 1'b0;
            hs_state <= hs_idle;
          end
        end
        default: begin
          hs_state <= hs_idle;
        end
      endcase
    end
  end

  // capture in the same cycle the handshake leaves idle
  always_ff @(posedge qdr_clk) begin
    if (hs_state == hs_idle && trans_rr) begin
      req_q <= host_req;
    end
  end

  // only the addressed lane changes, the other three keep older writes
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      shadow <= '0;
    end else if (burst_start && !req_q.rnw) begin
      shadow[word_id*lane_w +: lane_w] <= wr_lane;
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      rs_state     <= rs_idle;
      second_beat  <= 1'b0;
      ret_line     <= '0;
      sniff_strobe <= 1'b0;
    end else begin
      second_beat  <= 1'b0;
      sniff_strobe <= take_q;
      // start the latency count at the grant
      ret_line     <= {ret_line[qdr_latency-2:0], (rs_state == rs_wait) && cmd_ack};
      case (rs_state)
        rs_idle: begin
          if (burst_start) begin
            rs_state <= rs_wait;
          end
        end
        rs_wait: begin
          if (cmd_ack) begin
            second_beat <= 1'b1;
            rs_state    <= rs_collect;
          end
        end
        rs_collect: begin
          if (!req_q.rnw) begin
            rs_state <= rs_idle;
          end else if (ret_line[qdr_latency-1]) begin
            // upper beat needs one more cycle
            rs_state <= word_id[1] ? rs_final : rs_idle;
          end
        end
        rs_final: begin
          rs_state <= rs_idle;
        end
        default: begin
          rs_state <= rs_idle;
        end
      endcase
    end
  end

  // read word from the selected lane, stays put while resp is high
  always_ff @(posedge qdr_clk) begin
    if (take_q) begin
      rdata <= word_id[0] ? dev_q[lane_w +: host_data_w] : dev_q[host_data_w-1:0];
    end
  end

  always_comb begin
    cmd.r    = cmd_req & req_q.rnw;
    cmd.w    = cmd_req & ~req_q.rnw;
    cmd.addr = req_q.addr[31:4];
    cmd.d    = second_beat ? shadow[burst_w-1:beat_w] : shadow[beat_w-1:0];
    // enables only on the addressed beat, reads leave them off
    if (!req_q.rnw && (word_id[1] == second_beat)) begin
      cmd.be = lane_be;
    end else begin
      cmd.be = '0;
    end
  end

endmodule

//--- qdr_burst_sequencer.sv
`timescale 1ns/100ps

module qdr_burst_sequencer (
  input  logic                             qdr_clk,
  input  logic                             qdr_rst,
  input  logic                             cmd_req,
  input  qdr_pkg::qdr_cmd_t                cmd,
  input  logic                             dev_ready,
  output logic                             cmd_ack,
  output logic                             dev_r,
  output logic                             dev_w,
  output logic [qdr_pkg::burst_addr_w-1:0] dev_addr,
  output logic [qdr_pkg::beat_w-1:0]       dev_d,
  output logic [7:0]                       dev_be
);

  // grant cycle, beat 0 on the pins
  logic grant;

  // beat 1 of the last granted burst is on the pins
  logic beat1_q;

  // that burst was a write, so beat 1 carries data
  logic beat1_wr_q;

  // write data goes out in the grant cycle and the one after
  logic drive_data;

  // never grant into the beat-1 cycle, bursts cannot overlap
  assign grant   = cmd_req & dev_ready & ~beat1_q;
  assign cmd_ack = grant;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      beat1_q    <= 1'b0;
      beat1_wr_q <= 1'b0;
    end else begin
      beat1_q    <= grant;
      beat1_wr_q <= grant & cmd.w;
    end
  end

  assign drive_data = (grant & cmd.w) | beat1_wr_q;

  // strobes in beat 0 only
  assign dev_r = grant & cmd.r;
  assign dev_w = grant & cmd.w;

  // address for both beats, zero between bursts
  always_comb begin
    if (grant || beat1_q) begin
      dev_addr = cmd.addr;
    end else begin
      dev_addr = '0;
    end
  end

  // the bridge switches cmd.d and cmd.be to beat 1 after the ack
  always_comb begin
    if (drive_data) begin
      dev_d  = cmd.d;
      dev_be = cmd.be;
    end else begin
      dev_d  = '0;
      dev_be = '0;
    end
  end

endmodule

//--- qdr_cpu_subsystem.sv
`timescale 1ns/100ps

module qdr_cpu_subsystem (
  input  logic                             host_clk,
  input  logic                             host_rst,
  input  logic                             qdr_clk,
  input  logic                             qdr_rst,
  input  logic                             host_en,
  input  qdr_pkg::host_req_t               host_req,
  input  logic                             dev_ready,
  input  logic [qdr_pkg::beat_w-1:0]       dev_q,
  output logic                             host_ack,
  output logic [qdr_pkg::host_data_w-1:0]  host_rdata,
  output logic                             sniff_strobe,
  output logic                             dev_r,
  output logic                             dev_w,
  output logic [qdr_pkg::burst_addr_w-1:0] dev_addr,
  output logic [qdr_pkg::beat_w-1:0]       dev_d,
  output logic [7:0]                       dev_be
);

  import qdr_pkg::*;

  // handshake flags between the two clock domains
  logic trans;
  logic resp;

  // bridge to sequencer
  logic     cmd_req;
  logic     cmd_ack;
  qdr_cmd_t cmd;

  // host clock side of the crossing
  host_xfer_sync u_host_xfer_sync (
    .host_clk (host_clk),
    .host_rst (host_rst),
    .host_en  (host_en),
    .resp     (resp),
    .trans    (trans),
    .host_ack (host_ack)
  );

  // host_req and rdata cross without sync, both stable during the handshake
  qdr_cpu_bridge u_qdr_cpu_bridge (
    .qdr_clk      (qdr_clk),
    .qdr_rst      (qdr_rst),
    .trans        (trans),
    .host_req     (host_req),
    .cmd_ack      (cmd_ack),
    .dev_q        (dev_q),
    .resp         (resp),
    .rdata        (host_rdata),
    .cmd_req      (cmd_req),
    .cmd          (cmd),
    .sniff_strobe (sniff_strobe)
  );

  qdr_burst_sequencer u_qdr_burst_sequencer (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .dev_ready (dev_ready),
    .cmd_ack   (cmd_ack),
    .dev_r     (dev_r),
    .dev_w     (dev_w),
    .dev_addr  (dev_addr),
    .dev_d     (dev_d),
    .dev_be    (dev_be)
  );

endmodule

//--- tb_qdr_sram_model.sv
`timescale 1ns/100ps

module tb_qdr_sram_model (
  input  logic                             qdr_clk,
  input  logic                             qdr_rst,
  input  logic                             stall_en,
  input  logic                             dev_r,
  input  logic                             dev_w,
  input  logic [qdr_pkg::burst_addr_w-1:0] dev_addr,
  input  logic [qdr_pkg::beat_w-1:0]       dev_d,
  input  logic [7:0]                       dev_be,
  output logic                             dev_ready,
  output logic [qdr_pkg::beat_w-1:0]       dev_q
);

  import qdr_pkg::*;

  // one entry per beat, key is {burst address, beat}
  logic [beat_w-1:0] mem [bit [burst_addr_w:0]];

  // read pipeline, one stage per cycle of latency
  logic [qdr_latency-1:0]  rd_v;
  logic [burst_addr_w-1:0] rd_a [qdr_latency];

  // beat 1 of a write arrives one cycle after dev_w
  logic                    wr_beat1;
  logic [burst_addr_w-1:0] wr_a;

  integer seed;

  // beats never written read back as zero
  function automatic logic [beat_w-1:0] beat_read(input logic [burst_addr_w-1:0] a,
                                                  input logic b);
    if (mem.exists({a, b})) begin
      return mem[{a, b}];
    end
    return '0;
  endfunction

  // each enable covers one host byte of a 36-bit lane, pad bits stay zero
  task automatic beat_write(input logic [burst_addr_w-1:0] a, input logic b,
                            input logic [beat_w-1:0] d, input logic [7:0] be);
    logic [beat_w-1:0] cur;
    int                pos;
    cur = beat_read(a, b);
    for (int k = 0; k < 8; k++) begin
      pos = (k / 4) * lane_w + (k % 4) * 8;
      if (be[k]) begin
        cur[pos +: 8] = d[pos +: 8];
      end
    end
    mem[{a, b}] = cur;
  endtask

  // ready stalls about one cycle in four when enabled
  initial begin
    seed      = 32'h38e2213f;
    dev_ready = 1'b1;
    forever begin
      @(negedge qdr_clk);
      if (stall_en) begin
        dev_ready = ($random(seed) & 3) != 0;
      end else begin
        dev_ready = 1'b1;
      end
    end
  end

  initial dev_q = '0;

  always @(posedge qdr_clk) begin
    if (qdr_rst) begin
      rd_v     <= '0;
      wr_beat1 <= 1'b0;
      dev_q    <= '0;
    end else begin
      rd_v    <= {rd_v[qdr_latency-2:0], dev_r};
      rd_a[0] <= dev_addr;
      for (int k = 1; k < qdr_latency; k++) begin
        rd_a[k] <= rd_a[k-1];
      end
      if (dev_w) begin
        beat_write(dev_addr, 1'b0, dev_d, dev_be);
      end
      if (wr_beat1) begin
        beat_write(wr_a, 1'b1, dev_d, dev_be);
      end
      wr_beat1 <= dev_w;
      wr_a     <= dev_addr;
      // beat 0 shows qdr_latency cycles after the read strobe, beat 1 right after
      if (rd_v[qdr_latency-2]) begin
        dev_q <= beat_read(rd_a[qdr_latency-2], 1'b0);
      end else if (rd_v[qdr_latency-1]) begin
        dev_q <= beat_read(rd_a[qdr_latency-1], 1'b1);
      end else begin
        dev_q <= '0;
      end
    end
  end

endmodule

//--- tb_qdr_cpu.sv
`timescale 1ns/100ps

module tb_qdr_cpu;

  import qdr_pkg::*;

  logic qdr_clk, host_clk, qdr_rst, host_rst;
  logic host_en, host_ack, sniff_strobe, stall_en;
  logic dev_ready, dev_r, dev_w;
  host_req_t               host_req;
  logic [host_data_w-1:0]  host_rdata;
  logic [beat_w-1:0]       dev_q, dev_d;
  logic [burst_addr_w-1:0] dev_addr;
  logic [7:0]              dev_be;

  integer seed;
  int     err_count = 0;
  int     test_count = 0;
  int     test_fail = 0;
  int     xfer_count = 0;
  int     read_count = 0;
  int     ack_count = 0;
  int     sniff_count = 0;
  bit     hung = 0;
  // reset as seen one edge earlier when the DUT flops took their reset values
  bit     qdr_rst_q = 0;
  bit     host_rst_q = 0;
  // byte enables the current write must put on each beat
  logic [7:0] exp_be0, exp_be1;
  // expected memory keyed by word address
  bit [31:0] sb [bit [29:0]];

  qdr_cpu_subsystem dut0 (
    .host_clk (host_clk), .host_rst (host_rst), .qdr_clk (qdr_clk), .qdr_rst (qdr_rst),
    .host_en (host_en), .host_req (host_req), .dev_ready (dev_ready), .dev_q (dev_q),
    .host_ack (host_ack), .host_rdata (host_rdata), .sniff_strobe (sniff_strobe),
    .dev_r (dev_r), .dev_w (dev_w), .dev_addr (dev_addr), .dev_d (dev_d), .dev_be (dev_be)
  );

  tb_qdr_sram_model mem0 (
    .qdr_clk (qdr_clk), .qdr_rst (qdr_rst), .stall_en (stall_en), .dev_r (dev_r),
    .dev_w (dev_w), .dev_addr (dev_addr), .dev_d (dev_d), .dev_be (dev_be),
    .dev_ready (dev_ready), .dev_q (dev_q)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #20 qdr_clk = ~qdr_clk;
  end

  initial begin
    host_clk = 1'b0;
    forever #50 host_clk = ~host_clk;
  end

  always @(posedge qdr_clk) qdr_rst_q <= qdr_rst;
  always @(posedge host_clk) host_rst_q <= host_rst;

  // pulse counters compared against the transfers issued
  always @(posedge host_clk) if (host_ack) ack_count <= ack_count + 1;
  always @(posedge qdr_clk) if (sniff_strobe) sniff_count <= sniff_count + 1;

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  // quiet outputs in reset and in the first cycle after it
  assert property (@(posedge qdr_clk) qdr_rst_q |-> !dev_r && !dev_w)
    else report_error("device strobe during reset");
  assert property (@(posedge host_clk) host_rst_q |-> !host_ack)
    else report_error("host_ack during reset");
  // no command while the device is stalled
  assert property (@(posedge qdr_clk) (dev_r || dev_w) |-> dev_ready)
    else report_error("device strobe while dev_ready low");
  assert property (@(posedge qdr_clk) disable iff (qdr_rst) !(dev_r && dev_w))
    else report_error("read and write strobe together");
  assert property (@(posedge host_clk) disable iff (host_rst) host_ack |=> !host_ack)
    else report_error("host_ack longer than one cycle");
  // enables only on the addressed lane and beat
  assert property (@(posedge qdr_clk) disable iff (qdr_rst) dev_w |-> dev_be == exp_be0)
    else report_error("wrong byte enables on write beat 0");
  assert property (@(posedge qdr_clk) disable iff (qdr_rst) dev_w |=> dev_be == exp_be1)
    else report_error("wrong byte enables on write beat 1");
  assert property (@(posedge qdr_clk) disable iff (qdr_rst) dev_r |-> dev_be == 8'h00)
    else report_error("byte enables on a read");

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (sb.exists(addr[31:2])) begin
      return sb[addr[31:2]];
    end
    return 32'h0;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) begin
        res[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return res;
  endfunction

  // bit 3 picks the beat and bit 2 the upper or lower nibble
  function automatic logic [7:0] lane_enables(input logic [31:0] addr, input logic [3:0] be);
    return addr[2] ? {be, 4'b0000} : {4'b0000, be};
  endfunction

  task automatic host_xfer(input logic rnw, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    rdata = '0;
    waited = 0;
    if (hung) return;
    @(negedge host_clk);
    exp_be0       = (!rnw && !addr[3]) ? lane_enables(addr, be) : 8'h00;
    exp_be1       = (!rnw && addr[3]) ? lane_enables(addr, be) : 8'h00;
    host_req.rnw  = rnw;
    host_req.addr = addr;
    host_req.wdata = wdata;
    host_req.be   = be;
    host_en       = 1'b1;
    @(negedge host_clk);
    host_en = 1'b0;
    xfer_count++;
    if (rnw) read_count++;
    while (!host_ack && waited < 400) begin
      @(negedge host_clk);
      waited++;
    end
    if (!host_ack) begin
      hung = 1;
      err_count++;
      $display("transfer %0d (%s of address %h) hung, no host_ack after %0d cycles",
               xfer_count, rnw ? "read" : "write", addr, waited);
      return;
    end
    // rdata is valid in the ack cycle
    rdata = host_rdata;
    if (!rnw) sb[addr[31:2]] = merge_bytes(expected_word(addr), wdata, be);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] d, input logic [3:0] be);
    logic [31:0] unused;
    host_xfer(1'b0, addr, d, be, unused);
  endtask

  task automatic read_check(input logic [31:0] addr);
    logic [31:0] got;
    logic [31:0] exp;
    exp = expected_word(addr);
    host_xfer(1'b1, addr, 32'h0, 4'h0, got);
    if (!hung) begin
      assert (got === exp)
        else report_error($sformatf("read %h got %h expected %h", addr, got, exp));
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (!hung) begin
      // let the ack counter see the last pulse
      @(negedge host_clk);
      assert (ack_count == xfer_count)
        else report_error($sformatf("%0d host_ack for %0d transfers", ack_count, xfer_count));
      assert (sniff_count == read_count)
        else report_error($sformatf("%0d sniff_strobe for %0d reads", sniff_count, read_count));
    end
    test_count++;
    if (err_count != errs_before) begin
      test_fail++;
      $display("test %0d %s: FAILED", test_count, name);
    end else begin
      $display("test %0d %s: ok", test_count, name);
    end
  endtask

  initial begin
    int          errs;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] rnd;
    seed     = 32'h38e2213f;
    host_en  = 1'b0;
    host_req = '0;
    qdr_rst  = 1'b1;
    host_rst = 1'b1;
    stall_en = 1'b0;
    exp_be0  = 8'h00;
    exp_be1  = 8'h00;
    fork
      begin
        repeat (16) @(negedge qdr_clk);
        qdr_rst = 1'b0;
      end
      begin
        repeat (16) @(negedge host_clk);
        host_rst = 1'b0;
      end
    join

    errs = err_count;
    write_word(32'h0000_0100, 32'hcafe_0001, 4'hf);
    close_test("reset and first transfer", errs);

    errs = err_count;
    write_word(32'h0000_0204, 32'h1234_5678, 4'hf);
    read_check(32'h0000_0204);
    close_test("full word write and read", errs);

    // partial enables keep the other bytes
    errs = err_count;
    write_word(32'h0000_0308, 32'ha5a5_a5a5, 4'hf);
    write_word(32'h0000_0308, 32'h1122_3344, 4'b0101);
    read_check(32'h0000_0308);
    write_word(32'h0000_0308, 32'h99ff_ffff, 4'b1000);
    read_check(32'h0000_0308);
    close_test("partial byte enables", errs);

    // all four words of one burst on both beats and both lanes
    errs = err_count;
    for (int k = 0; k < 4; k++) write_word(32'h0000_0400 + 4 * k, $random(seed), 4'hf);
    for (int k = 0; k < 4; k++) read_check(32'h0000_0400 + 4 * k);
    close_test("four words of a burst", errs);

    errs = err_count;
    @(negedge qdr_clk);
    stall_en = 1'b1;
    for (int k = 0; k < 8; k++) begin
      write_word(32'h0000_0600 + 4 * k, $random(seed), 4'hf);
      read_check(32'h0000_0600 + 4 * (7 - k));
    end
    close_test("dev_ready stalls", errs);

    // random mix over four bursts with stalls still on
    errs = err_count;
    for (int k = 0; k < 40; k++) begin
      a = 32'h0000_0800 + (($random(seed) & 15) << 2);
      if ($random(seed) & 1) begin
        read_check(a);
      end else begin
        wd  = $random(seed);
        rnd = $random(seed);
        write_word(a, wd, rnd[3:0]);
      end
    end
    close_test("random sequence", errs);

    $display("%0d tests, %0d failed, %0d errors, %0d transfers",
             test_count, test_fail, err_count, xfer_count);
    if (err_count == 0 && !hung) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- build.f
qdr_pkg.sv
host_xfer_sync.sv
qdr_cpu_bridge.sv
qdr_burst_sequencer.sv
qdr_cpu_subsystem.sv
tb_qdr_sram_model.sv
tb_qdr_cpu.sv

//--- Bender.yml
package:
  name: qdr_cpu

sources:
  - qdr_pkg.sv
  - host_xfer_sync.sv
  - qdr_cpu_bridge.sv
  - qdr_burst_sequencer.sv
  - qdr_cpu_subsystem.sv
  - target: simulation
    files:
      - tb_qdr_sram_model.sv
      - tb_qdr_cpu.sv
